//--- verilog.f
source/bridge_pkg.sv
source/request_tracker.sv
source/read_issue.sv
source/write_issue.sv
source/read_capture.sv
source/mem_bridge.sv
verif/mem_bridge_checker.sv
verif/bus_responder.sv
verif/tb_mem_bridge.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         := tb_mem_bridge
RTL_TOP     := mem_bridge
FILELIST    := verilog.f
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing
OBJ_DIR     := obj_dir
LOG         := sim.log
FAIL_MSG    := Test failures found
PASS_MSG    := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bridge;

	// one stimulus row, expected strobe covers the single store of the row
	typedef struct packed {
		logic                  fetch;
		bridge_pkg::word_t     pc;
		bridge_pkg::lane_req_t l0;
		bridge_pkg::lane_req_t l1;
		logic                  fwd;
		bridge_pkg::strb_t     strb;
	} row_t;

	localparam int NUM_ROWS = 14;
	localparam int TIMEOUT  = 200;
	localparam bridge_pkg::lane_req_t NO_REQ = '0;

	logic clk;
	logic data_w_ok_1;
	bridge_pkg::lane_req_t lane0_req;
	bridge_pkg::lane_req_t lane1_req;
	logic fetch_req;
	bridge_pkg::word_t fetch_pc;
	bridge_pkg::lane_status_t lane0_status;
	bridge_pkg::lane_status_t lane1_status;
	bridge_pkg::word_t inst0;
	bridge_pkg::word_t inst1;
	logic inst_pair_valid;
	logic stall;
	bridge_pkg::rd_addr_t ar;
	logic arready;
	bridge_pkg::rd_beat_t rd;
	logic aw_valid;
	bridge_pkg::word_t aw_addr;
	logic awready;
	bridge_pkg::wr_beat_t w;
	logic wready;
	bridge_pkg::word_t wr_count;
	bridge_pkg::word_t wr_addr;
	bridge_pkg::word_t wr_data;
	bridge_pkg::strb_t wr_strb;
	bridge_pkg::word_t id2_reads;
	row_t rows [NUM_ROWS];

	mem_bridge uut (
		.clk             (clk),
		.data_w_ok_1     (data_w_ok_1),
		.lane0_req       (lane0_req),
		.lane1_req       (lane1_req),
		.fetch_req       (fetch_req),
		.fetch_pc        (fetch_pc),
		.lane0_status    (lane0_status),
		.lane1_status    (lane1_status),
		.inst0           (inst0),
		.inst1           (inst1),
		.inst_pair_valid (inst_pair_valid),
		.stall           (stall),
		.ar              (ar),
		.arready         (arready),
		.rd              (rd),
		.aw_valid        (aw_valid),
		.aw_addr         (aw_addr),
		.awready         (awready),
		.w               (w),
		.wready          (wready)
	);

	bus_responder u_responder (
		.clk       (clk),
		.ar        (ar),
		.arready   (arready),
		.rd        (rd),
		.aw_valid  (aw_valid),
		.aw_addr   (aw_addr),
		.awready   (awready),
		.w         (w),
		.wready    (wready),
		.wr_count  (wr_count),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_strb   (wr_strb),
		.id2_reads (id2_reads)
	);

	bind mem_bridge mem_bridge_checker u_checker (
		.clk         (clk),
		.data_w_ok_1 (data_w_ok_1),
		.ar          (ar),
		.aw_valid    (aw_valid),
		.w           (w),
		.wready      (wready),
		.lane0_req   (lane0_req),
		.lane1_req   (lane1_req),
		.fetch_req   (fetch_req),
		.stall       (stall)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// request builders and compare tasks
	////////////////////////////////////////////////////////////

	function automatic bridge_pkg::lane_req_t load_req(input bridge_pkg::word_t addr);
		return '{load: 1'b1, store: 1'b0, addr: addr, wdata: '0, size: bridge_pkg::SIZE_WORD};
	endfunction

	function automatic bridge_pkg::lane_req_t store_req(input bridge_pkg::word_t addr,
		input bridge_pkg::word_t data, input bridge_pkg::size_t size);
		return '{load: 1'b0, store: 1'b1, addr: addr, wdata: data, size: size};
	endfunction

	function automatic bridge_pkg::lane_status_t done_status(input bridge_pkg::word_t data);
		return '{load_done: 1'b1, store_done: 1'b0, rdata: data};
	endfunction

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input bridge_pkg::word_t got,
		input bridge_pkg::word_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic compare_strb(input string name, input bridge_pkg::strb_t got,
		input bridge_pkg::strb_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic verify_status(input string name, input bridge_pkg::lane_status_t got,
		input bridge_pkg::lane_status_t exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	// the responder keeps the last accepted write
	task automatic match_write_log(input bridge_pkg::lane_req_t req,
		input bridge_pkg::strb_t strb);
		check_word("wr_addr", wr_addr, req.addr);
		check_word("wr_data", wr_data, req.wdata);
		compare_strb("wr_strb", wr_strb, strb);
	endtask

	////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////

	task automatic fill_table();
		rows[0] = '{1'b1, 32'h0000_1000, NO_REQ, NO_REQ, 1'b0, 4'b0000};
		rows[1] = '{1'b0, 32'h0, load_req(32'h2000_0010), NO_REQ, 1'b0, 4'b0000};
		rows[2] = '{1'b0, 32'h0, NO_REQ, load_req(32'h2000_0024), 1'b0, 4'b0000};
		rows[3] = '{1'b1, 32'h0000_2040, load_req(32'h3000_0100),
			load_req(32'h3000_0204), 1'b0, 4'b0000};
		// byte strobes walk across the word
		rows[4] = '{1'b0, 32'h0, store_req(32'h6000_0000, 32'h1122_3344,
			bridge_pkg::SIZE_BYTE), NO_REQ, 1'b0, 4'b0001};
		rows[5] = '{1'b0, 32'h0, store_req(32'h6000_0001, 32'h5566_7788,
			bridge_pkg::SIZE_BYTE), NO_REQ, 1'b0, 4'b0010};
		rows[6] = '{1'b0, 32'h0, NO_REQ, store_req(32'h6000_0012, 32'h99aa_bbcc,
			bridge_pkg::SIZE_BYTE), 1'b0, 4'b0100};
		rows[7] = '{1'b0, 32'h0, store_req(32'h6000_0023, 32'hddee_ff00,
			bridge_pkg::SIZE_BYTE), NO_REQ, 1'b0, 4'b1000};
		// halfwords, address bit 1 picks the upper half
		rows[8] = '{1'b0, 32'h0, store_req(32'h6000_0100, 32'h0bad_f00d,
			bridge_pkg::SIZE_HALF), NO_REQ, 1'b0, 4'b0011};
		rows[9] = '{1'b0, 32'h0, NO_REQ, store_req(32'h6000_0202, 32'hcafe_d00d,
			bridge_pkg::SIZE_HALF), 1'b0, 4'b1100};
		rows[10] = '{1'b0, 32'h0, store_req(32'h6000_0301, 32'h1357_9bdf,
			bridge_pkg::SIZE_HALF), NO_REQ, 1'b0, 4'b0011};
		rows[11] = '{1'b0, 32'h0, store_req(32'h6000_0400, 32'h2468_ace0,
			bridge_pkg::SIZE_WORD), NO_REQ, 1'b0, 4'b1111};
		// lane 1 load hits the lane 0 store
		rows[12] = '{1'b0, 32'h0, store_req(32'h4000_0080, 32'hdead_beef,
			bridge_pkg::SIZE_WORD), load_req(32'h4000_0080), 1'b1, 4'b1111};
		rows[13] = '{1'b0, 32'h0, load_req(32'h5000_0008), store_req(32'h5000_000c,
			32'h7777_0001, bridge_pkg::SIZE_WORD), 1'b0, 4'b1111};
	endtask

	// drive one row, then watch done pulses and stall until the row completes
	task automatic run_row(input int idx);
		row_t r;
		logic [4:0] need;
		logic [4:0] seen;
		int cycles;
		bridge_pkg::word_t writes_before;
		bridge_pkg::word_t reads_before;
		bridge_pkg::word_t exp_reads;
		r = rows[idx];
		writes_before = wr_count;
		reads_before = id2_reads;
		@(posedge clk);
		#2;
		lane0_req = r.l0;
		lane1_req = r.l1;
		fetch_req = r.fetch;
		fetch_pc = r.pc;
		need = {r.fetch, r.l0.load, r.l1.load, r.l0.store, r.l1.store};
		seen = '0;
		cycles = 0;
		while (seen != need)
		begin
			@(posedge clk);
			#1;
			if (inst_pair_valid)
			begin
				check_word("inst0", inst0, ~r.pc);
				check_word("inst1", inst1, ~(r.pc + 32'd4));
				seen[4] = 1'b1;
			end
			if (lane0_status.load_done)
			begin
				verify_status("lane0_status", lane0_status, done_status(~r.l0.addr));
				seen[3] = 1'b1;
			end
			if (lane1_status.load_done)
			begin
				verify_status("lane1_status", lane1_status,
					done_status(r.fwd ? r.l0.wdata : ~r.l1.addr));
				seen[2] = 1'b1;
			end
			if (lane0_status.store_done)
			begin
				match_write_log(r.l0, r.strb);
				seen[1] = 1'b1;
			end
			if (lane1_status.store_done)
			begin
				match_write_log(r.l1, r.strb);
				seen[0] = 1'b1;
			end
			// any outstanding request keeps stall up until its done pulse
			if ((need & ~seen) != 5'b00000)
				expect_flag("stall", stall, 1'b1);
			cycles++;
			if ((seen != need) && (cycles >= TIMEOUT))
			begin
				$display("row %0d timed out waiting for its done pulses", idx);
				stop_run();
			end
		end
		expect_flag("stall", stall, 1'b0);
		#1;
		lane0_req = NO_REQ;
		lane1_req = NO_REQ;
		fetch_req = 1'b0;
		check_word("wr_count", wr_count,
			writes_before + {31'd0, r.l0.store} + {31'd0, r.l1.store});
		exp_reads = reads_before;
		if (r.l1.load && !r.fwd)
			exp_reads = reads_before + 32'd1;
		check_word("id2_reads", id2_reads, exp_reads);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		data_w_ok_1 = 1'b0;
		lane0_req = NO_REQ;
		lane1_req = NO_REQ;
		fetch_req = 1'b0;
		fetch_pc = '0;
		fill_table();
		#1;
		data_w_ok_1 = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		data_w_ok_1 = 1'b0;
		#1;
		// control outputs quiet out of reset
		expect_flag("ar.valid", ar.valid, 1'b0);
		expect_flag("aw_valid", aw_valid, 1'b0);
		expect_flag("w.valid", w.valid, 1'b0);
		expect_flag("w.last", w.last, 1'b0);
		expect_flag("lane0_status.load_done", lane0_status.load_done, 1'b0);
		expect_flag("lane0_status.store_done", lane0_status.store_done, 1'b0);
		expect_flag("lane1_status.load_done", lane1_status.load_done, 1'b0);
		expect_flag("lane1_status.store_done", lane1_status.store_done, 1'b0);
		expect_flag("inst_pair_valid", inst_pair_valid, 1'b0);
		expect_flag("stall", stall, 1'b0);
		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);
		repeat (2) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/bus_responder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_responder (
	input  wire                        clk,
	input  wire bridge_pkg::rd_addr_t  ar,
	output logic                       arready,
	output bridge_pkg::rd_beat_t       rd,
	input  wire                        aw_valid,
	input  wire bridge_pkg::word_t     aw_addr,
	output logic                       awready,
	input  wire bridge_pkg::wr_beat_t  w,
	output logic                       wready,
	output bridge_pkg::word_t          wr_count,
	output bridge_pkg::word_t          wr_addr,
	output bridge_pkg::word_t          wr_data,
	output bridge_pkg::strb_t          wr_strb,
	output bridge_pkg::word_t          id2_reads
);

	bridge_pkg::rd_addr_t pend [$];
	bridge_pkg::rd_addr_t cur;
	bridge_pkg::word_t aw_hold;
	logic busy;
	int beats_left;
	int ar_wait;
	int r_wait;
	int w_wait;

	// single process so one random stream drives every delay
	initial
	begin
		void'($urandom(32'hc5cb));
		arready = 1'b0;
		awready = 1'b1;
		wready = 1'b0;
		rd = '0;
		wr_count = '0;
		wr_addr = '0;
		wr_data = '0;
		wr_strb = '0;
		id2_reads = '0;
		aw_hold = '0;
		cur = '0;
		busy = 1'b0;
		beats_left = 0;
		ar_wait = 0;
		r_wait = 0;
		w_wait = $urandom_range(3, 0);
		forever
		begin
			@(posedge clk);
			#2;
			if (ar_wait > 0)
			begin
				arready = 1'b0;
				ar_wait--;
			end
			else
				arready = 1'b1;
			if (w_wait > 0)
			begin
				wready = 1'b0;
				w_wait--;
			end
			else
				wready = 1'b1;

			////////////////////////////////////////////////////////////
			// read beats, one burst at a time in request order
			////////////////////////////////////////////////////////////

			rd = '0;
			if (!busy && (pend.size() > 0))
			begin
				cur = pend.pop_front();
				busy = 1'b1;
				beats_left = int'(cur.len) + 1;
				r_wait = $urandom_range(3, 0);
			end
			if (busy)
			begin
				if (r_wait > 0)
					r_wait--;
				else
				begin
					// data is the inverted beat address
					rd = '{valid: 1'b1, id: cur.id, data: ~cur.addr};
					cur.addr = cur.addr + 32'd4;
					beats_left--;
					busy = (beats_left > 0);
					r_wait = $urandom_range(3, 0);
				end
			end

			// sample the bus mid cycle
			@(negedge clk);
			if (ar.valid)
			begin
				pend.push_back(ar);
				if (ar.id == bridge_pkg::ID_LOAD1)
					id2_reads = id2_reads + 32'd1;
				ar_wait = $urandom_range(3, 0);
			end
			if (aw_valid)
				aw_hold = aw_addr;
			// beat is taken at the coming edge
			if (w.valid && wready)
			begin
				wr_addr = aw_hold;
				wr_data = w.data;
				wr_strb = w.strb;
				wr_count = wr_count + 32'd1;
				w_wait = $urandom_range(3, 0);
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/mem_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_checker (
	input wire                              clk,
	input wire                              data_w_ok_1,
	input wire bridge_pkg::rd_addr_t        ar,
	input wire                              aw_valid,
	input wire bridge_pkg::wr_beat_t        w,
	input wire                              wready,
	input wire bridge_pkg::lane_req_t       lane0_req,
	input wire bridge_pkg::lane_req_t       lane1_req,
	input wire                              fetch_req,
	input wire                              stall
);

	logic [4:0] req_lvl;

	// every request level the lanes can raise
	assign req_lvl = {fetch_req, lane0_req.load, lane1_req.load, lane0_req.store,
		lane1_req.store};

	// arvalid is a one cycle pulse
	ar_single: assert property (@(posedge clk) disable iff (data_w_ok_1)
		ar.valid |=> !ar.valid)
		else $error("ar.valid stayed high for two cycles");

	// single beat writes, held while wready is low
	w_last: assert property (@(posedge clk) disable iff (data_w_ok_1)
		(w.valid && !wready) |=> (w.valid && w.last && $stable(w)))
		else $error("write beat changed or lost last under back-pressure");

	// a new request raises stall on the next cycle
	stall_cover: assert property (@(posedge clk) disable iff (data_w_ok_1)
		((req_lvl & ~$past(req_lvl)) != 5'b00000) |=> stall)
		else $error("stall low while a request is outstanding");

	////////////////////////////////////////////////////////////
	// quiet bus in reset
	////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk)
		data_w_ok_1 |-> (!ar.valid && !aw_valid && !w.valid))
		else $error("bus activity during reset");

endmodule

`default_nettype wire

//--- source/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge (
	input  wire                            clk,
	input  wire                            data_w_ok_1,
	input  wire bridge_pkg::lane_req_t     lane0_req,
	input  wire bridge_pkg::lane_req_t     lane1_req,
	input  wire                            fetch_req,
	input  wire bridge_pkg::word_t         fetch_pc,
	output wire bridge_pkg::lane_status_t  lane0_status,
	output wire bridge_pkg::lane_status_t  lane1_status,
	output wire bridge_pkg::word_t         inst0,
	output wire bridge_pkg::word_t         inst1,
	output wire                            inst_pair_valid,
	output wire                            stall,
	output wire bridge_pkg::rd_addr_t      ar,
	input  wire                            arready,
	input  wire bridge_pkg::rd_beat_t      rd,
	output wire                            aw_valid,
	output wire bridge_pkg::word_t         aw_addr,
	input  wire                            awready,
	output wire bridge_pkg::wr_beat_t      w,
	input  wire                            wready
);

	wire [bridge_pkg::NUM_LANES-1:0] load_pending;
	wire [bridge_pkg::NUM_LANES-1:0] store_pending;
	wire [bridge_pkg::NUM_LANES-1:0] load_done;
	wire [bridge_pkg::NUM_LANES-1:0] store_done;
	wire [bridge_pkg::NUM_LANES-1:0] w_accept;
	wire fetch_pending;
	wire forward_hit;
	wire bridge_pkg::word_t load_word0;
	wire bridge_pkg::word_t load_word1;

	////////////////////////////////////////////////////////////
	// tracking, issue, capture
	////////////////////////////////////////////////////////////

	request_tracker u_tracker (
		.clk           (clk),
		.data_w_ok_1   (data_w_ok_1),
		.lane0_req     (lane0_req),
		.lane1_req     (lane1_req),
		.fetch_req     (fetch_req),
		.rd            (rd),
		.w_accept      (w_accept),
		.load_pending  (load_pending),
		.store_pending (store_pending),
		.fetch_pending (fetch_pending),
		.forward_hit   (forward_hit),
		.load_done     (load_done),
		.store_done    (store_done),
		.stall         (stall)
	);

	read_issue u_read_issue (
		.clk           (clk),
		.data_w_ok_1   (data_w_ok_1),
		.fetch_pc      (fetch_pc),
		.lane0_req     (lane0_req),
		.lane1_req     (lane1_req),
		.load_pending  (load_pending),
		.fetch_pending (fetch_pending),
		.forward_hit   (forward_hit),
		.arready       (arready),
		.rd            (rd),
		.ar            (ar)
	);

	write_issue u_write_issue (
		.clk           (clk),
		.data_w_ok_1   (data_w_ok_1),
		.lane0_req     (lane0_req),
		.lane1_req     (lane1_req),
		.store_pending (store_pending),
		.awready       (awready),
		.wready        (wready),
		.aw_valid      (aw_valid),
		.aw_addr       (aw_addr),
		.w             (w),
		.w_accept      (w_accept)
	);

	read_capture u_read_capture (
		.clk             (clk),
		.data_w_ok_1     (data_w_ok_1),
		.rd              (rd),
		.forward_hit     (forward_hit),
		.lane0_req       (lane0_req),
		.inst0           (inst0),
		.inst1           (inst1),
		.inst_pair_valid (inst_pair_valid),
		.load_word0      (load_word0),
		.load_word1      (load_word1)
	);

	// status words back to the lanes
	assign lane0_status = '{load_done: load_done[0], store_done: store_done[0],
		rdata: load_word0};
	assign lane1_status = '{load_done: load_done[1], store_done: store_done[1],
		rdata: load_word1};

endmodule

`default_nettype wire

//--- source/read_capture.sv
`timescale 1ns/1ps
`default_nettype none

module read_capture (
	input  wire                         clk,
	input  wire                         data_w_ok_1,
	input  wire bridge_pkg::rd_beat_t   rd,
	input  wire                         forward_hit,
	input  wire bridge_pkg::lane_req_t  lane0_req,
	output bridge_pkg::word_t           inst0,
	output bridge_pkg::word_t           inst1,
	output logic                        inst_pair_valid,
	output bridge_pkg::word_t           load_word0,
	output bridge_pkg::word_t           load_word1
);

	// low means the next fetch beat goes to inst0
	logic beat_ptr;
	logic fetch_beat;
	logic load0_beat;
	logic load1_beat;

	assign fetch_beat = rd.valid && (rd.id == bridge_pkg::ID_FETCH);
	assign load0_beat = rd.valid && (rd.id == bridge_pkg::ID_LOAD0);
	assign load1_beat = rd.valid && (rd.id == bridge_pkg::ID_LOAD1);

	always_ff @(posedge clk or posedge data_w_ok_1)
	begin
		if (data_w_ok_1)
		begin
			beat_ptr        <= 1'b0;
			inst_pair_valid <= 1'b0;
		end
		else
		begin
			// pair done on the second beat
			inst_pair_valid <= fetch_beat && beat_ptr;
			if (fetch_beat)
				beat_ptr <= !beat_ptr;
		end
	end

	////////////////////////////////////////////////////////////
	// data words
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (fetch_beat && !beat_ptr)
			inst0 <= rd.data;
		if (fetch_beat && beat_ptr)
			inst1 <= rd.data;
		if (load0_beat)
			load_word0 <= rd.data;
		// lane 1 reads the store data of lane 0 on a hit
		if (forward_hit)
			load_word1 <= lane0_req.wdata;
		else if (load1_beat)
			load_word1 <= rd.data;
	end

endmodule

`default_nettype wire

//--- source/write_issue.sv
`timescale 1ns/1ps
`default_nettype none

module write_issue (
	input  wire                              clk,
	input  wire                              data_w_ok_1,
	input  wire bridge_pkg::lane_req_t       lane0_req,
	input  wire bridge_pkg::lane_req_t       lane1_req,
	input  wire [bridge_pkg::NUM_LANES-1:0]  store_pending,
	input  wire                              awready,
	input  wire                              wready,
	output logic                             aw_valid,
	output bridge_pkg::word_t                aw_addr,
	output bridge_pkg::wr_beat_t             w,
	output logic [bridge_pkg::NUM_LANES-1:0] w_accept
);

	bridge_pkg::lane_req_t req [bridge_pkg::NUM_LANES];
	logic busy;
	logic lane_sel;
	logic pick;
	logic start;
	logic w_valid;
	bridge_pkg::word_t w_data;
	bridge_pkg::strb_t w_strb;

	// byte lane enables from size and address
	function automatic bridge_pkg::strb_t decode_strb(
		input bridge_pkg::size_t size,
		input logic [1:0]        addr_lo
	);
		bridge_pkg::strb_t strb;
		case (size)
			bridge_pkg::SIZE_BYTE:
				strb = bridge_pkg::STRB_BYTE << addr_lo;
			// address bit 1 picks the upper half
			bridge_pkg::SIZE_HALF:
				strb = addr_lo[1] ? bridge_pkg::STRB_HALF_HI : bridge_pkg::STRB_HALF_LO;
			bridge_pkg::SIZE_WORD:
				strb = bridge_pkg::STRB_WORD;
			default:
				strb = bridge_pkg::STRB_WORD;
		endcase
		return strb;
	endfunction

	assign req[0] = lane0_req;
	assign req[1] = lane1_req;

	// lane 0 wins when both stores wait
	assign pick  = !store_pending[0];
	assign start = !busy && awready && (|store_pending);

	////////////////////////////////////////////////////////////
	// address pulse, then one data beat
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge data_w_ok_1)
	begin
		if (data_w_ok_1)
		begin
			busy     <= 1'b0;
			lane_sel <= 1'b0;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end
		else
		begin
			aw_valid <= start;
			if (start)
			begin
				busy     <= 1'b1;
				lane_sel <= pick;
			end
			else if (w_valid && wready)
				busy <= 1'b0;
			if (aw_valid)
				w_valid <= 1'b1;
			else if (w_valid && wready)
				w_valid <= 1'b0;
		end
	end

	// beat contents stay put while wready is low
	always_ff @(posedge clk)
	begin
		if (start)
			aw_addr <= req[pick].addr;
		if (aw_valid)
		begin
			w_data <= req[lane_sel].wdata;
			w_strb <= decode_strb(req[lane_sel].size, req[lane_sel].addr[1:0]);
		end
	end

	// every store is a single beat, so last follows valid
	assign w = '{valid: w_valid, last: w_valid, data: w_data, strb: w_strb};

	always_comb
	begin
		w_accept[0] = w_valid && wready && !lane_sel;
		w_accept[1] = w_valid && wready && lane_sel;
	end

endmodule

`default_nettype wire

//--- source/read_issue.sv
`timescale 1ns/1ps
`default_nettype none

module read_issue (
	input  wire                              clk,
	input  wire                              data_w_ok_1,
	input  wire bridge_pkg::word_t           fetch_pc,
	input  wire bridge_pkg::lane_req_t       lane0_req,
	input  wire bridge_pkg::lane_req_t       lane1_req,
	input  wire [bridge_pkg::NUM_LANES-1:0]  load_pending,
	input  wire                              fetch_pending,
	input  wire                              forward_hit,
	input  wire                              arready,
	input  wire bridge_pkg::rd_beat_t        rd,
	output bridge_pkg::rd_addr_t             ar
);

	logic fetch_applied;
	logic [bridge_pkg::NUM_LANES-1:0] load_applied;
	logic fetch_go;
	logic [bridge_pkg::NUM_LANES-1:0] load_go;
	logic [2:0] grant;
	logic issue;
	logic ar_valid;
	bridge_pkg::bus_id_t ar_id;
	bridge_pkg::word_t ar_addr;
	logic [3:0] ar_len;

	assign fetch_go   = fetch_pending && !fetch_applied;
	assign load_go[0] = load_pending[0] && !load_applied[0];
	// a forwarded load never reaches the bus
	assign load_go[1] = load_pending[1] && !load_applied[1] && !forward_hit;

	// no issue right after a pulse, so arvalid stays one cycle wide
	assign issue = arready && !ar_valid && (fetch_go || (|load_go));

	// fetch, then lane 0, then lane 1
	assign grant[0] = issue && fetch_go;
	assign grant[1] = issue && !fetch_go && load_go[0];
	assign grant[2] = issue && !fetch_go && !load_go[0] && load_go[1];

	////////////////////////////////////////////////////////////
	// applied flags and the arvalid pulse
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge data_w_ok_1)
	begin
		if (data_w_ok_1)
		begin
			ar_valid      <= 1'b0;
			fetch_applied <= 1'b0;
			load_applied  <= '0;
		end
		else
		begin
			ar_valid <= issue;
			if (grant[0])
				fetch_applied <= 1'b1;
			else if (!fetch_pending)
				fetch_applied <= 1'b0;
			if (grant[1])
				load_applied[0] <= 1'b1;
			else if (rd.valid && (rd.id == bridge_pkg::ID_LOAD0))
				load_applied[0] <= 1'b0;
			if (grant[2])
				load_applied[1] <= 1'b1;
			else if (rd.valid && (rd.id == bridge_pkg::ID_LOAD1))
				load_applied[1] <= 1'b0;
		end
	end

	// address channel payload
	always_ff @(posedge clk)
	begin
		if (grant[0])
		begin
			ar_id   <= bridge_pkg::ID_FETCH;
			ar_addr <= fetch_pc;
			ar_len  <= bridge_pkg::FETCH_LEN;
		end
		else if (grant[1])
		begin
			ar_id   <= bridge_pkg::ID_LOAD0;
			ar_addr <= lane0_req.addr;
			ar_len  <= bridge_pkg::LOAD_LEN;
		end
		else if (grant[2])
		begin
			ar_id   <= bridge_pkg::ID_LOAD1;
			ar_addr <= lane1_req.addr;
			ar_len  <= bridge_pkg::LOAD_LEN;
		end
	end

	assign ar = '{valid: ar_valid, id: ar_id, addr: ar_addr, len: ar_len};

endmodule

`default_nettype wire

//--- source/request_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module request_tracker (
	input  wire                                  clk,
	input  wire                                  data_w_ok_1,
	input  wire bridge_pkg::lane_req_t           lane0_req,
	input  wire bridge_pkg::lane_req_t           lane1_req,
	input  wire                                  fetch_req,
	input  wire bridge_pkg::rd_beat_t            rd,
	input  wire [bridge_pkg::NUM_LANES-1:0]      w_accept,
	output logic [bridge_pkg::NUM_LANES-1:0]     load_pending,
	output logic [bridge_pkg::NUM_LANES-1:0]     store_pending,
	output logic                                 fetch_pending,
	output logic                                 forward_hit,
	output logic [bridge_pkg::NUM_LANES-1:0]     load_done,
	output logic [bridge_pkg::NUM_LANES-1:0]     store_done,
	output logic                                 stall
);

	// done means answered, waiting for the lane to drop its request
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PEND,
		ST_FWD,
		ST_DONE
	} req_state_t;

	typedef enum logic [1:0] {
		F_IDLE,
		F_WAIT,
		F_HALF,
		F_DONE
	} fetch_state_t;

	bridge_pkg::lane_req_t req [bridge_pkg::NUM_LANES];
	req_state_t ld_state [bridge_pkg::NUM_LANES];
	req_state_t st_state [bridge_pkg::NUM_LANES];
	fetch_state_t fetch_state;
	logic [bridge_pkg::NUM_LANES-1:0] beat_hit;
	logic fetch_beat;
	logic fresh_ld1;
	logic fwd_match;

	assign req[0] = lane0_req;
	assign req[1] = lane1_req;

	assign beat_hit[0] = rd.valid && (rd.id == bridge_pkg::ID_LOAD0);
	assign beat_hit[1] = rd.valid && (rd.id == bridge_pkg::ID_LOAD1);
	assign fetch_beat  = rd.valid && (rd.id == bridge_pkg::ID_FETCH);

	// only checked on the first pending cycle, before lane 1 can reach the bus
	assign fwd_match = fresh_ld1 && (st_state[0] == ST_PEND)
		&& (lane1_req.addr == lane0_req.addr);
	assign forward_hit = fwd_match || (ld_state[1] == ST_FWD);

	////////////////////////////////////////////////////////////
	// per-lane load and store state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge data_w_ok_1)
	begin
		if (data_w_ok_1)
		begin
			for (int i = 0; i < bridge_pkg::NUM_LANES; i++)
			begin
				ld_state[i]   <= ST_IDLE;
				st_state[i]   <= ST_IDLE;
				load_done[i]  <= 1'b0;
				store_done[i] <= 1'b0;
			end
			fresh_ld1   <= 1'b0;
			fetch_state <= F_IDLE;
		end
		else
		begin
			fresh_ld1 <= (ld_state[1] == ST_IDLE) && lane1_req.load;
			for (int i = 0; i < bridge_pkg::NUM_LANES; i++)
			begin
				load_done[i]  <= 1'b0;
				store_done[i] <= 1'b0;
				case (ld_state[i])
					ST_IDLE:
						if (req[i].load)
							ld_state[i] <= ST_PEND;
					ST_PEND:
					begin
						if (beat_hit[i])
						begin
							ld_state[i]  <= ST_DONE;
							load_done[i] <= 1'b1;
						end
						else if ((i == 1) && fwd_match)
							ld_state[i] <= ST_FWD;
					end
					// data is taken from lane 0 this cycle
					ST_FWD:
					begin
						ld_state[i]  <= ST_DONE;
						load_done[i] <= 1'b1;
					end
					default:
						if (!req[i].load)
							ld_state[i] <= ST_IDLE;
				endcase
				case (st_state[i])
					ST_IDLE:
						if (req[i].store)
							st_state[i] <= ST_PEND;
					ST_PEND:
					begin
						if (w_accept[i])
						begin
							st_state[i]   <= ST_DONE;
							store_done[i] <= 1'b1;
						end
					end
					default:
						if (!req[i].store)
							st_state[i] <= ST_IDLE;
				endcase
			end

			// two beats make a fetch
			case (fetch_state)
				F_IDLE:
					if (fetch_req)
						fetch_state <= F_WAIT;
				F_WAIT:
					if (fetch_beat)
						fetch_state <= F_HALF;
				F_HALF:
					if (fetch_beat)
						fetch_state <= F_DONE;
				default:
					if (!fetch_req)
						fetch_state <= F_IDLE;
			endcase
		end
	end

	always_comb
	begin
		for (int i = 0; i < bridge_pkg::NUM_LANES; i++)
		begin
			load_pending[i]  = (ld_state[i] == ST_PEND);
			store_pending[i] = (st_state[i] == ST_PEND);
		end
	end

	assign fetch_pending = (fetch_state == F_WAIT) || (fetch_state == F_HALF);

	// stall covers the forwarded load too
	assign stall = (|load_pending) || (|store_pending) || fetch_pending
		|| (ld_state[1] == ST_FWD);

endmodule

`default_nettype wire

//--- source/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

	////////////////////////////////////////////////////////////
	// basic words
	////////////////////////////////////////////////////////////

	// two execution lanes share the bridge
	localparam int NUM_LANES = 2;

	typedef logic [31:0] word_t;
	typedef logic [1:0]  size_t;
	typedef logic [3:0]  bus_id_t;
	typedef logic [3:0]  strb_t;

	// access size encoding from the lanes
	localparam size_t SIZE_BYTE = 2'd0;
	localparam size_t SIZE_HALF = 2'd1;
	localparam size_t SIZE_WORD = 2'd2;

	// read ids, one per source
	localparam bus_id_t ID_FETCH = 4'd0;
	localparam bus_id_t ID_LOAD0 = 4'd1;
	localparam bus_id_t ID_LOAD1 = 4'd2;

	// burst length is beats minus one
	localparam logic [3:0] FETCH_LEN = 4'd1;
	localparam logic [3:0] LOAD_LEN  = 4'd0;

	// strobe patterns, byte pattern is shifted by the low address bits
	localparam strb_t STRB_BYTE    = 4'b0001;
	localparam strb_t STRB_HALF_LO = 4'b0011;
	localparam strb_t STRB_HALF_HI = 4'b1100;
	localparam strb_t STRB_WORD    = 4'b1111;

	////////////////////////////////////////////////////////////
	// lane side
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic  load;
		logic  store;
		word_t addr;
		word_t wdata;
		size_t size;
	} lane_req_t;

	typedef struct packed {
		logic  load_done;
		logic  store_done;
		word_t rdata;
	} lane_status_t;

	////////////////////////////////////////////////////////////
	// bus side
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       valid;
		bus_id_t    id;
		word_t      addr;
		logic [3:0] len;
	} rd_addr_t;

	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
		strb_t strb;
	} wr_beat_t;

	typedef struct packed {
		logic    valid;
		bus_id_t id;
		word_t   data;
	} rd_beat_t;

endpackage

`default_nettype wire
